/* rtl/fifo_geom_pkg.sv */
// FIFO geometry: word width, depth and the address, count and data types

package fifo_geom_pkg;

   // --------------------
   // Sizes
   // --------------------
   localparam int DATA_W = 18;           // Bits per stored word
   localparam int DEPTH  = 8;            // Words in the array
   localparam int ADDR_W = 3;            // Enough to index DEPTH words

   // Count spans 0..DEPTH inclusive, so one bit above the address
   localparam int CNT_W  = ADDR_W + 1;

   // --------------------
   // Types
   // --------------------

   // One stored word
   typedef logic [DATA_W-1:0] data_t;

   // Memory address, wraps at DEPTH
   typedef logic [ADDR_W-1:0] addr_t;

   // Occupancy, 0 to DEPTH
   typedef logic [CNT_W-1:0]  count_t;

endpackage

/* rtl/fifo_flag_pkg.sv */
// FIFO status thresholds: almost-full, almost-empty and full occupancy levels

package fifo_flag_pkg;

   import fifo_geom_pkg::*;

   // --------------------
   // Almost flags
   // --------------------

   // Almost-full high at or above this occupancy
   localparam count_t AFULL_VAL  = count_t'(6);

   // Almost-empty high at or below this occupancy
   localparam count_t AEMPTY_VAL = count_t'(2);

   // --------------------
   // Hard limits
   // --------------------

   // Every slot in use
   localparam count_t FULL_LEVEL = count_t'(DEPTH);

endpackage

/* rtl/fifo_req_gate.sv */
// Request gate: qualifies write and read strobes and reports ack and error pulses
`timescale 1ns/1ns

module fifo_req_gate (
   input  logic pos_clk,
   input  logic aresetn,
   input  logic we_i,         // Write request from user
   input  logic re_i,         // Read request from user
   input  logic full_i,       // Registered full flag
   input  logic empty_i,      // Registered empty flag
   output logic wr_ok_o,      // Accepted write, same cycle
   output logic rd_ok_o,      // Accepted read, same cycle
   output logic wack_o,       // One cycle after accepted write
   output logic overflow_o,   // One cycle after write into full
   output logic underflow_o   // One cycle after read from empty
);

   // --------------------
   // Qualified strobes
   // --------------------

   // Flags are registered, so no loop through the gate
   assign wr_ok_o = we_i & ~full_i;
   assign rd_ok_o = re_i & ~empty_i;

   // Refused requests
   logic wr_refused;
   logic rd_refused;

   assign wr_refused = we_i & full_i;    // Write dropped, word lost
   assign rd_refused = re_i & empty_i;   // Read dropped, rdata untouched

   // --------------------
   // Pulses
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         // Each pulse lasts exactly one cycle per request cycle
         wack_o      <= wr_ok_o;
         overflow_o  <= wr_refused;
         underflow_o <= rd_refused;
      end
   end

endmodule

/* rtl/fifo_occupancy.sv */
// Occupancy counter with registered full, almost-full, empty and almost-empty flags
`timescale 1ns/1ns

module fifo_occupancy
   import fifo_geom_pkg::*;
   import fifo_flag_pkg::*;
(
   input  logic   pos_clk,
   input  logic   aresetn,
   input  logic   wr_ok_i,    // Accepted write
   input  logic   rd_ok_i,    // Accepted read
   output count_t count_o,    // Words held
   output logic   full_o,
   output logic   afull_o,
   output logic   empty_o,
   output logic   aempty_o
);

   // --------------------
   // Counter
   // --------------------
   count_t cnt_q;   // Current occupancy
   count_t cnt_d;   // Occupancy after this edge

   // Next value
   // Write alone counts up, read alone counts down
   // Both or neither leave the level where it is
   always_comb begin
      unique case ({wr_ok_i, rd_ok_i})
         2'b10:   cnt_d = cnt_q + count_t'(1);   // Push only
         2'b01:   cnt_d = cnt_q - count_t'(1);   // Pop only
         default: cnt_d = cnt_q;                 // Idle or push+pop
      endcase
   end

   // Gate never lets an accepted write through at FULL_LEVEL,
   // nor an accepted read at zero, so no saturation is needed
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_d;
      end
   end

   assign count_o = cnt_q;   // Straight from the register

   // --------------------
   // Status flags
   // --------------------

   // Compared against the next value, so each flag lands on the
   // same edge as the count and is never a cycle behind it
   logic full_d;
   logic afull_d;
   logic empty_d;
   logic aempty_d;

   assign full_d   = (cnt_d == FULL_LEVEL);   // All slots used
   assign afull_d  = (cnt_d >= AFULL_VAL);    // Nearing full
   assign empty_d  = (cnt_d == '0);           // Nothing stored
   assign aempty_d = (cnt_d <= AEMPTY_VAL);   // Nearly drained

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         // Empty FIFO after reset
         full_o   <= 1'b0;
         afull_o  <= 1'b0;
         empty_o  <= 1'b1;
         aempty_o <= 1'b1;
      end else begin
         full_o   <= full_d;
         afull_o  <= afull_d;
         empty_o  <= empty_d;
         aempty_o <= aempty_d;
      end
   end

   // Flag sequence while filling from empty:
   //   count 1 -> empty drops
   //   count 3 -> aempty drops
   //   count 6 -> afull rises
   //   count 8 -> full rises
   // Draining runs the same thresholds in reverse:
   //   count 7 -> full drops
   //   count 5 -> afull drops
   //   count 2 -> aempty rises
   //   count 0 -> empty rises

endmodule

/* rtl/fifo_storage.sv */
// FIFO storage: wrapping pointers, word array and registered read data with valid
`timescale 1ns/1ns

module fifo_storage
   import fifo_geom_pkg::*;
(
   input  logic  pos_clk,
   input  logic  aresetn,
   input  logic  wr_ok_i,    // Accepted write
   input  logic  rd_ok_i,    // Accepted read
   input  data_t wdata_i,    // Word to store
   output data_t rdata_o,    // Word read, held until next read
   output logic  dvld_o      // One cycle after accepted read
);

   // --------------------
   // Pointers
   // --------------------
   addr_t wr_ptr;   // Next slot to fill
   addr_t rd_ptr;   // Oldest stored word

   // DEPTH is a power of two, so the pointers wrap on their own
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok_i) begin
            wr_ptr <= wr_ptr + addr_t'(1);
         end
         if (rd_ok_i) begin
            rd_ptr <= rd_ptr + addr_t'(1);
         end
      end
   end

   // --------------------
   // Array
   // --------------------
   data_t mem [DEPTH];

   // Pointers only meet when full or empty, and the gate refuses
   // the write or the read there, so no same-slot collision
   always_ff @(posedge pos_clk) begin
      if (wr_ok_i) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   // --------------------
   // Read port
   // --------------------

   // Data register, loads only on a read
   always_ff @(posedge pos_clk) begin
      if (rd_ok_i) begin
         rdata_o <= mem[rd_ptr];
      end
   end

   // Valid pulse lines up with the new data
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_o <= 1'b0;
      end else begin
         dvld_o <= rd_ok_i;
      end
   end

endmodule

/* rtl/fifo_top.sv */
// Synchronous FIFO top: request gate, occupancy and storage stages
`timescale 1ns/1ns

module fifo_top
   import fifo_geom_pkg::*;
(
   input  logic   pos_clk,
   input  logic   aresetn,
   input  logic   we_i,
   input  logic   re_i,
   input  data_t  wdata_i,
   output logic   full_o,
   output logic   afull_o,
   output logic   empty_o,
   output logic   aempty_o,
   output count_t count_o,
   output logic   wack_o,
   output logic   overflow_o,
   output logic   underflow_o,
   output logic   dvld_o,
   output data_t  rdata_o
);

   logic wr_ok;   // Gate to counter and array
   logic rd_ok;

   // --------------------
   // Request gate
   // --------------------
   fifo_req_gate u_gate (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .full_i      (full_o),    // Fed back from occupancy
      .empty_i     (empty_o),
      .wr_ok_o     (wr_ok),
      .rd_ok_o     (rd_ok),
      .wack_o      (wack_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // --------------------
   // Occupancy and flags
   // --------------------
   fifo_occupancy u_occ (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_ok_i  (wr_ok),
      .rd_ok_i  (rd_ok),
      .count_o  (count_o),
      .full_o   (full_o),
      .afull_o  (afull_o),
      .empty_o  (empty_o),
      .aempty_o (aempty_o)
   );

   // --------------------
   // Storage
   // --------------------
   fifo_storage u_mem (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .wr_ok_i (wr_ok),
      .rd_ok_i (rd_ok),
      .wdata_i (wdata_i),
      .rdata_o (rdata_o),
      .dvld_o  (dvld_o)
   );

endmodule

/* include/fifo_tb_checks.svh */
// Compare tasks for the FIFO testbench, one per DUT output type
`ifndef FIFO_TB_CHECKS_SVH
`define FIFO_TB_CHECKS_SVH

// --------------------
// Single-bit outputs
// --------------------
task automatic check_flag(
   input  string       name,      // Signal under test
   input  logic        exp_v,
   input  logic        act_v,
   inout  int unsigned err_cnt    // Running mismatch total
);
   if (act_v !== exp_v) begin
      $display("FAILED %s at %0t: expected %h, got %h", name, $time, exp_v, act_v);
      err_cnt++;
   end
endtask

// --------------------
// Occupancy
// --------------------
task automatic check_count(
   input  string       name,
   input  count_t      exp_v,     // Type from fifo_geom_pkg
   input  count_t      act_v,
   inout  int unsigned err_cnt
);
   if (act_v !== exp_v) begin
      $display("FAILED %s at %0t: expected %h, got %h", name, $time, exp_v, act_v);
      err_cnt++;
   end
endtask

// --------------------
// Read data
// --------------------
task automatic check_data(
   input  string       name,
   input  data_t       exp_v,
   input  data_t       act_v,
   inout  int unsigned err_cnt
);
   if (act_v !== exp_v) begin
      $display("FAILED %s at %0t: expected %h, got %h", name, $time, exp_v, act_v);
      err_cnt++;
   end
endtask

`endif

/* dv/fifo_tb.sv */
// FIFO testbench: file-driven per-cycle stimulus with checks against expected outputs
`timescale 1ns/1ns

module fifo_tb
   import fifo_geom_pkg::*;
();

   `include "fifo_tb_checks.svh"

   // --------------------
   // Run constants
   // --------------------
   localparam string STIM_FILE  = "dv/fifo_stimulus.txt";
   localparam int    NUM_TESTS  = 6;     // Last test number expected in the file
   localparam int    RST_CYCLES = 16;
   localparam int    RST_WAIT   = 20;    // Cycles allowed for the idle state after reset
   localparam int    MAX_CYCLES = 400;   // Watchdog limit
   localparam int    DRIVE_DLY  = 10;    // After the rising edge
   localparam int    SAMPLE_DLY = 80;    // From drive to sample, 10 ns before the edge

   // One stimulus line, inputs then expected outputs
   typedef struct {
      int     test;
      logic   we;
      logic   re;
      data_t  wdata;
      logic   full;
      logic   afull;
      logic   empty;
      logic   aempty;
      count_t count;
      logic   wack;
      logic   ovf;
      logic   udf;
      logic   dvld;
      bit     rchk;     // Clear where rdata is not compared
      data_t  rdata;
   } row_t;

   // DUT ports
   logic   pos_clk;
   logic   aresetn;
   logic   we_i;
   logic   re_i;
   data_t  wdata_i;
   logic   full_o;
   logic   afull_o;
   logic   empty_o;
   logic   aempty_o;
   count_t count_o;
   logic   wack_o;
   logic   overflow_o;
   logic   underflow_o;
   logic   dvld_o;
   data_t  rdata_o;

   row_t        rows [$];         // Whole file, loaded before reset ends
   bit          load_err  = 1'b0;
   bit          setup_err = 1'b0;
   int          cur_test  = 0;    // Test whose lines are being checked
   int unsigned test_errs = 0;
   int unsigned pass_cnt  = 0;
   int unsigned fail_cnt  = 0;

   fifo_top DUT (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .wdata_i     (wdata_i),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .count_o     (count_o),
      .wack_o      (wack_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o),
      .dvld_o      (dvld_o),
      .rdata_o     (rdata_o)
   );

   // 100 ns period
   initial begin
      pos_clk = 1'b0;
      forever #50 pos_clk = ~pos_clk;
   end

   // --------------------
   // Stimulus file
   // --------------------
   task automatic load_rows();
      int          fd;
      int          n;
      string       line;
      string       rd_s;
      logic [31:0] f_t, f_we, f_re, f_wd, f_fu, f_af, f_em, f_ae;
      logic [31:0] f_cn, f_wk, f_ov, f_ud, f_dv, f_rd;
      row_t        r;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file %s", STIM_FILE);
         load_err = 1'b1;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin   // Skip blanks and comments
               n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %s", f_t, f_we,
                           f_re, f_wd, f_fu, f_af, f_em, f_ae, f_cn, f_wk, f_ov, f_ud,
                           f_dv, rd_s);
               if (n != 14) begin
                  $display("Stimulus line could not be parsed: %s", line);
                  load_err = 1'b1;
               end else begin
                  r.test   = int'(f_t);
                  r.we     = f_we[0];
                  r.re     = f_re[0];
                  r.wdata  = data_t'(f_wd);
                  r.full   = f_fu[0];
                  r.afull  = f_af[0];
                  r.empty  = f_em[0];
                  r.aempty = f_ae[0];
                  r.count  = count_t'(f_cn);
                  r.wack   = f_wk[0];
                  r.ovf    = f_ov[0];
                  r.udf    = f_ud[0];
                  r.dvld   = f_dv[0];
                  r.rchk   = (rd_s != "-");   // Dash means no rdata compare
                  f_rd     = '0;
                  if (r.rchk) begin
                     n = $sscanf(rd_s, "%h", f_rd);
                  end
                  r.rdata  = data_t'(f_rd);
                  rows.push_back(r);
               end
            end
         end
         $fclose(fd);
         if (rows.size() == 0 || rows[rows.size()-1].test < NUM_TESTS) begin
            $display("The stimulus file ends before test %0d", NUM_TESTS);
            load_err = 1'b1;
         end
      end
   endtask

   // --------------------
   // Drive and check
   // --------------------
   task automatic drive_row(input row_t r);
      we_i    = r.we;
      re_i    = r.re;
      wdata_i = r.wdata;
   endtask

   task automatic drive_idle();
      we_i    = 1'b0;
      re_i    = 1'b0;
      wdata_i = '0;
   endtask

   // Per-test verdict line
   task automatic close_test();
      if (test_errs == 0) begin
         $display("Test %0d passed", cur_test);
         pass_cnt++;
      end else begin
         $display("Test %0d failed with %0d mismatches", cur_test, test_errs);
         fail_cnt++;
      end
   endtask

   task automatic check_row(input row_t r);
      if (r.test != cur_test) begin   // New test starts here
         if (cur_test != 0) begin
            close_test();
         end
         cur_test  = r.test;
         test_errs = 0;
      end
      check_flag("full_o", r.full, full_o, test_errs);
      check_flag("afull_o", r.afull, afull_o, test_errs);
      check_flag("empty_o", r.empty, empty_o, test_errs);
      check_flag("aempty_o", r.aempty, aempty_o, test_errs);
      check_count("count_o", r.count, count_o, test_errs);
      check_flag("wack_o", r.wack, wack_o, test_errs);
      check_flag("overflow_o", r.ovf, overflow_o, test_errs);
      check_flag("underflow_o", r.udf, underflow_o, test_errs);
      check_flag("dvld_o", r.dvld, dvld_o, test_errs);
      if (r.rchk) begin
         check_data("rdata_o", r.rdata, rdata_o, test_errs);
      end
   endtask

   // Idle FIFO expected once reset is released
   task automatic wait_reset_idle();
      int waited;
      waited = 0;
      while ((empty_o !== 1'b1 || count_o !== '0) && waited < RST_WAIT) begin
         @(posedge pos_clk);
         waited++;
      end
      if (empty_o !== 1'b1 || count_o !== '0) begin
         $display("The DUT did not reach the empty state after reset");
         setup_err = 1'b1;
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      int k;
      aresetn = 1'b0;
      drive_idle();
      load_rows();
      repeat (RST_CYCLES) @(posedge pos_clk);
      #DRIVE_DLY;
      aresetn = 1'b1;
      wait_reset_idle();
      if (!load_err && !setup_err) begin
         // Line k is driven while line k-1 is checked
         for (k = 0; k <= rows.size(); k++) begin
            @(posedge pos_clk);
            #DRIVE_DLY;
            if (k < rows.size()) begin
               drive_row(rows[k]);
            end else begin
               drive_idle();
            end
            #SAMPLE_DLY;
            if (k > 0) begin
               check_row(rows[k-1]);
            end
         end
         if (cur_test != 0) begin
            close_test();
         end
      end
      $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
      if (!load_err && !setup_err && fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Watchdog
   initial begin
      int n;
      for (n = 0; n < MAX_CYCLES; n++) begin
         @(posedge pos_clk);
      end
      $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* dv/fifo_stimulus.txt */
# Columns: test we re wdata | expected full afull empty aempty count wack ovf udf dvld rdata
# Hex values; expected ones hold after the edge that takes the inputs; rdata - is not checked

# Test 1: eight writes from empty
1 1 0 00011  0 0 0 1 1 1 0 0 0 -
1 1 0 10022  0 0 0 1 2 1 0 0 0 -
1 1 0 20033  0 0 0 0 3 1 0 0 0 -
1 1 0 30044  0 0 0 0 4 1 0 0 0 -
1 1 0 3ff55  0 0 0 0 5 1 0 0 0 -
1 1 0 0a066  0 1 0 0 6 1 0 0 0 -
1 1 0 15a77  0 1 0 0 7 1 0 0 0 -
1 1 0 2c388  1 1 0 0 8 1 0 0 0 -

# Test 2: write while full
2 1 0 3abcd  1 1 0 0 8 0 1 0 0 -
2 0 0 00000  1 1 0 0 8 0 0 0 0 -

# Test 3: read and write together while full
3 1 1 0beef  0 1 0 0 7 0 1 0 1 00011
3 0 0 00000  0 1 0 0 7 0 0 0 0 00011

# Test 4: drain in write order
4 0 1 00000  0 1 0 0 6 0 0 0 1 10022
4 0 1 00000  0 0 0 0 5 0 0 0 1 20033
4 0 1 00000  0 0 0 0 4 0 0 0 1 30044
4 0 1 00000  0 0 0 0 3 0 0 0 1 3ff55
4 0 1 00000  0 0 0 1 2 0 0 0 1 0a066
4 0 1 00000  0 0 0 1 1 0 0 0 1 15a77
4 0 1 00000  0 0 1 1 0 0 0 0 1 2c388

# Test 5: read while empty
5 0 1 00000  0 0 1 1 0 0 0 1 0 2c388
5 0 0 00000  0 0 1 1 0 0 0 0 0 2c388

# Test 6: fill to four, then reads and writes together, then drain
6 1 0 1f001  0 0 0 1 1 1 0 0 0 2c388
6 1 0 1f002  0 0 0 1 2 1 0 0 0 2c388
6 1 0 1f003  0 0 0 0 3 1 0 0 0 2c388
6 1 0 1f004  0 0 0 0 4 1 0 0 0 2c388
6 1 1 2e101  0 0 0 0 4 1 0 0 1 1f001
6 1 1 2e102  0 0 0 0 4 1 0 0 1 1f002
6 1 1 2e103  0 0 0 0 4 1 0 0 1 1f003
6 1 1 2e104  0 0 0 0 4 1 0 0 1 1f004
6 1 1 2e105  0 0 0 0 4 1 0 0 1 2e101
6 0 1 00000  0 0 0 0 3 0 0 0 1 2e102
6 0 1 00000  0 0 0 1 2 0 0 0 1 2e103
6 0 1 00000  0 0 0 1 1 0 0 0 1 2e104
6 0 1 00000  0 0 1 1 0 0 0 0 1 2e105
6 0 0 00000  0 0 1 1 0 0 0 0 0 2e105

/* fifo_sync.f */
+incdir+include
rtl/fifo_geom_pkg.sv
rtl/fifo_flag_pkg.sv
rtl/fifo_req_gate.sv
rtl/fifo_occupancy.sv
rtl/fifo_storage.sv
rtl/fifo_top.sv
dv/fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the FIFO testbench with Verilator, run it, and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

# Compile and build the simulation model
if ! verilator --binary -j 0 --top-module fifo_tb -Mdir "$OBJ" -f fifo_sync.f; then
    echo "Verilator build failed"
    exit 1
fi

# Run from the project root so the stimulus path resolves
if ! "./$OBJ/Vfifo_tb" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation run returned an error status"
    exit 1
fi

cat "$LOG"

# Verdict comes from the pass line in the log
if grep -qx "Simulation finished: PASS" "$LOG"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail"
exit 1
